//--- design/frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// program counter width
`define PC_W 32

// instruction word width
`define INSTR_W 32

// first fetch address out of reset
`define PC_RESET 32'h1C00_0000

// instruction buffer entries, power of two
`define IB_DEPTH 8

`endif

//--- design/frontend_pkg.sv
`default_nettype none

`include "frontend_params.svh"

package frontend_pkg;

  typedef logic [`PC_W-1:0] pc_t;

  typedef logic [`INSTR_W-1:0] instr_t;

  // one fetched instruction with its address
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
  } fetch_entry_t;

endpackage

`default_nettype wire

//--- design/fetch_push_if.sv
`timescale 1ns/100ps
`default_nettype none

// fetch unit to instruction buffer, valid/ready
interface fetch_push_if;
  import frontend_pkg::*;

  logic         valid;
  logic         ready;
  fetch_entry_t entry;

  modport producer (
    output valid,
    output entry,
    input  ready
  );

  modport buffer (
    input  valid,
    input  entry,
    output ready
  );

endinterface

`default_nettype wire

//--- design/ib_pop_if.sv
`timescale 1ns/100ps
`default_nettype none

// two oldest buffer entries out, pop count back
interface ib_pop_if;
  import frontend_pkg::*;

  fetch_entry_t entry0;
  logic         valid0;
  fetch_entry_t entry1;
  logic         valid1;
  logic [1:0]   pop_num;

  modport buffer (
    output entry0,
    output valid0,
    output entry1,
    output valid1,
    input  pop_num
  );

  modport issue (
    input  entry0,
    input  valid0,
    input  entry1,
    input  valid1,
    output pop_num
  );

endinterface

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "frontend_params.svh"

module fetch_unit (
  input  wire                       aclk,
  input  wire                       i_rst_n,
  input  wire                       i_redirect,
  input  wire frontend_pkg::pc_t    i_redirect_pc,
  input  wire                       i_imem_addr_ok,
  input  wire                       i_imem_data_ok,
  input  wire frontend_pkg::instr_t i_imem_rdata,
  output logic                      o_imem_valid,
  output frontend_pkg::pc_t         o_imem_addr,
  fetch_push_if.producer            push
);
  import frontend_pkg::*;

  pc_t          fetch_pc;
  pc_t          next_pc;
  logic         outstanding;
  logic         stale;
  logic         hold_valid;
  fetch_entry_t hold_entry;

  logic         accept;
  logic         done;
  logic         fresh;
  logic         push_fire;
  logic         busy_next;
  logic         hold_empty_next;
  logic         start;

  assign accept    = o_imem_valid & i_imem_addr_ok;
  assign done      = outstanding & i_imem_data_ok;
  // a word returned after a redirect is dropped
  assign fresh     = done & ~stale & ~i_redirect;
  assign push_fire = push.valid & push.ready;

  // request pending or in flight after this edge
  assign busy_next = o_imem_valid | (outstanding & ~i_imem_data_ok);

  assign hold_empty_next = i_redirect | (~fresh & (~hold_valid | push_fire));

  // a word loaded now may overlap the next request only if the buffer
  // has room, so the holding register is certain to drain next edge
  assign start = ~busy_next &
                 (hold_empty_next | (fresh & ~push_fire & push.ready));

  assign next_pc = i_redirect ? i_redirect_pc : fetch_pc;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_imem_valid <= 1'b0;
      outstanding  <= 1'b0;
      stale        <= 1'b0;
      hold_valid   <= 1'b0;
      fetch_pc     <= `PC_RESET;
    end else begin
      o_imem_valid <= (o_imem_valid & ~i_imem_addr_ok) | start;
      outstanding  <= accept | (outstanding & ~i_imem_data_ok);
      fetch_pc     <= start ? next_pc + `PC_W'(4) : next_pc;
      // whatever is still pending or in flight belongs to the old stream
      if (i_redirect) begin
        stale <= busy_next;
      end else if (done) begin
        stale <= 1'b0;
      end
      hold_valid <= fresh | (hold_valid & ~push_fire & ~i_redirect);
    end
  end

  // request address stays put until addr_ok, and through data_ok
  always_ff @(posedge aclk) begin
    if (start) begin
      o_imem_addr <= next_pc;
    end
    if (fresh) begin
      hold_entry.pc    <= o_imem_addr;
      hold_entry.instr <= i_imem_rdata;
    end
  end

  assign push.valid = hold_valid;
  assign push.entry = hold_entry;

endmodule

`default_nettype wire

//--- design/instr_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "frontend_params.svh"

// circular buffer, one push and up to two pops per cycle
// DEPTH must be a power of two, 4 or more
module instr_buffer #(
  parameter int DEPTH = `IB_DEPTH
) (
  input  wire          aclk,
  input  wire          i_rst_n,
  input  wire          i_flush,
  fetch_push_if.buffer push,
  ib_pop_if.buffer     pop
);
  import frontend_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  fetch_entry_t     ib_mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nx;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             push_fire;

  assign push_fire = push.valid & push.ready;

  // room for at least one more entry
  assign push.ready = (count != CNT_W'(DEPTH));

  // second oldest wraps with the pointer
  assign rd_ptr_nx = rd_ptr + 1'b1;

  assign pop.entry0 = ib_mem[rd_ptr];
  assign pop.entry1 = ib_mem[rd_ptr_nx];
  assign pop.valid0 = (count != '0);
  assign pop.valid1 = (count > CNT_W'(1));

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (i_flush) begin
      // redirect drops everything, including a push on this edge
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + PTR_W'(pop.pop_num);
      count  <= count + CNT_W'(push_fire) - CNT_W'(pop.pop_num);
    end
  end

  always_ff @(posedge aclk) begin
    if (push_fire) begin
      ib_mem[wr_ptr] <= push.entry;
    end
  end

endmodule

`default_nettype wire

//--- design/issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
  input  wire                  aclk,
  input  wire                  i_rst_n,
  input  wire                  i_flush,
  input  wire                  i_issue_ready,
  ib_pop_if.issue              pop,
  output logic                 o_issue0_valid,
  output frontend_pkg::pc_t    o_issue0_pc,
  output frontend_pkg::instr_t o_issue0_instr,
  output logic                 o_issue1_valid,
  output frontend_pkg::pc_t    o_issue1_pc,
  output frontend_pkg::instr_t o_issue1_instr
);
  import frontend_pkg::*;

  fetch_entry_t slot0;
  fetch_entry_t slot1;
  logic         can_load;

  // slots empty, or both taken on this edge
  assign can_load = ~o_issue0_valid | i_issue_ready;

  always_comb begin
    if (!can_load) begin
      pop.pop_num = 2'd0;
    end else if (pop.valid1) begin
      pop.pop_num = 2'd2;
    end else if (pop.valid0) begin
      pop.pop_num = 2'd1;
    end else begin
      pop.pop_num = 2'd0;
    end
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_issue0_valid <= 1'b0;
      o_issue1_valid <= 1'b0;
    end else if (i_flush) begin
      o_issue0_valid <= 1'b0;
      o_issue1_valid <= 1'b0;
    end else if (can_load) begin
      // slot 0 always gets the oldest entry
      o_issue0_valid <= pop.valid0;
      o_issue1_valid <= pop.valid1;
    end
  end

  always_ff @(posedge aclk) begin
    if (can_load) begin
      slot0 <= pop.entry0;
      slot1 <= pop.entry1;
    end
  end

  assign o_issue0_pc    = slot0.pc;
  assign o_issue0_instr = slot0.instr;
  assign o_issue1_pc    = slot1.pc;
  assign o_issue1_instr = slot1.instr;

endmodule

`default_nettype wire

//--- design/frontend_top.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_top (
  input  wire                       aclk,
  input  wire                       i_rst_n,
  // jump target, flushes the whole front end
  input  wire                       i_redirect,
  input  wire frontend_pkg::pc_t    i_redirect_pc,
  // instruction memory
  output logic                      o_imem_valid,
  output frontend_pkg::pc_t         o_imem_addr,
  input  wire                       i_imem_addr_ok,
  input  wire                       i_imem_data_ok,
  input  wire frontend_pkg::instr_t i_imem_rdata,
  // issue slots
  input  wire                       i_issue_ready,
  output logic                      o_issue0_valid,
  output frontend_pkg::pc_t         o_issue0_pc,
  output frontend_pkg::instr_t      o_issue0_instr,
  output logic                      o_issue1_valid,
  output frontend_pkg::pc_t         o_issue1_pc,
  output frontend_pkg::instr_t      o_issue1_instr
);
  import frontend_pkg::*;

  fetch_push_if u_push_if ();
  ib_pop_if     u_pop_if ();

  fetch_unit u_fetch_unit (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_redirect     (i_redirect),
    .i_redirect_pc  (i_redirect_pc),
    .i_imem_addr_ok (i_imem_addr_ok),
    .i_imem_data_ok (i_imem_data_ok),
    .i_imem_rdata   (i_imem_rdata),
    .o_imem_valid   (o_imem_valid),
    .o_imem_addr    (o_imem_addr),
    .push           (u_push_if.producer)
  );

  instr_buffer u_instr_buffer (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_flush (i_redirect),
    .push    (u_push_if.buffer),
    .pop     (u_pop_if.buffer)
  );

  issue_stage u_issue_stage (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_flush        (i_redirect),
    .i_issue_ready  (i_issue_ready),
    .pop            (u_pop_if.issue),
    .o_issue0_valid (o_issue0_valid),
    .o_issue0_pc    (o_issue0_pc),
    .o_issue0_instr (o_issue0_instr),
    .o_issue1_valid (o_issue1_valid),
    .o_issue1_pc    (o_issue1_pc),
    .o_issue1_instr (o_issue1_instr)
  );

endmodule

`default_nettype wire

//--- verification/frontend_chk.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_chk (
  input wire                    aclk,
  input wire                    i_rst_n,
  input wire                    i_imem_valid,
  input wire                    i_imem_addr_ok,
  input wire frontend_pkg::pc_t i_imem_addr,
  input wire                    i_issue0_valid,
  input wire                    i_issue1_valid
);

  int fail_count = 0;

  // request and its address held until addr_ok
  a_addr_stable : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (i_imem_valid && !i_imem_addr_ok) |=> (i_imem_valid && $stable(i_imem_addr))
  ) else begin
    $error("memory request address changed before addr_ok");
    fail_count++;
  end

  // slots fill in order
  a_slot_order : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    i_issue1_valid |-> i_issue0_valid
  ) else begin
    $error("issue slot 1 valid without slot 0");
    fail_count++;
  end

endmodule

bind frontend_top frontend_chk u_chk (
  .aclk           (aclk),
  .i_rst_n        (i_rst_n),
  .i_imem_valid   (o_imem_valid),
  .i_imem_addr_ok (i_imem_addr_ok),
  .i_imem_addr    (o_imem_addr),
  .i_issue0_valid (o_issue0_valid),
  .i_issue1_valid (o_issue1_valid)
);

`default_nettype wire

//--- verification/frontend_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "frontend_params.svh"

module frontend_tb;
  import frontend_pkg::*;

  localparam int CLK_HALF         = 20;
  localparam int RST_CYCLES       = 4;
  localparam int CYCLES_PER_INSTR = 40;
  localparam int MAX_WORDS        = 256;

  logic   aclk;
  logic   i_rst_n;
  logic   i_redirect;
  pc_t    i_redirect_pc;
  logic   o_imem_valid;
  pc_t    o_imem_addr;
  logic   i_imem_addr_ok;
  logic   i_imem_data_ok;
  instr_t i_imem_rdata;
  logic   i_issue_ready;
  logic   o_issue0_valid;
  pc_t    o_issue0_pc;
  instr_t o_issue0_instr;
  logic   o_issue1_valid;
  pc_t    o_issue1_pc;
  instr_t o_issue1_instr;

  logic [31:0] tests_mem [MAX_WORDS];
  int          n_image;
  int          n_redirect;
  int          n_instr;
  int          redir_base;
  bit          loaded;
  integer      seed;

  // memory responder state
  bit  req_outstanding;
  bit  addr_counting;
  bit  data_wait;
  int  addr_delay;
  int  data_delay;
  pc_t req_addr;

  // reference model state
  pc_t    exp_pc;
  int     issued;
  int     redir_idx;
  bit     redir_pending;
  int     active_cycles;
  int     both_seen;
  int     stall_left;
  bit     hold_check;
  logic   hold_v0;
  logic   hold_v1;
  pc_t    hold_pc0;
  pc_t    hold_pc1;
  instr_t hold_in0;
  instr_t hold_in1;

  frontend_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #CLK_HALF aclk = ~aclk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("ERROR time=%0t: %s", $time, what);
    abort_run();
  endtask

  // words outside the image follow an address-derived fill
  function automatic instr_t image_word(input pc_t addr);
    instr_t word;
    word = addr ^ 32'h5A5A_F00F;
    for (int k = 0; k < n_image; k++) begin
      if (tests_mem[3 + 2 * k] == addr) begin
        word = tests_mem[4 + 2 * k];
      end
    end
    return word;
  endfunction

  task automatic memory_port_rules();
    if (active_cycles == 1) begin
      assert (!o_issue0_valid && !o_issue1_valid)
        else report_error("issue valid high right after reset");
      assert (!o_imem_valid) else report_error("memory request during reset");
    end
    if (active_cycles == 2) begin
      assert (o_imem_valid) else report_error("no memory request after reset");
      assert (o_imem_addr == `PC_RESET)
        else report_mismatch("o_imem_addr", o_imem_addr, `PC_RESET);
    end
    if (req_outstanding) begin
      assert (!o_imem_valid) else report_error("new request while one is outstanding");
    end
  endtask

  task automatic respond_memory();
    i_imem_data_ok <= 1'b0;
    if (i_imem_data_ok) begin
      req_outstanding = 1'b0;
    end
    if (o_imem_valid && i_imem_addr_ok) begin
      i_imem_addr_ok <= 1'b0;
      req_outstanding = 1'b1;
      req_addr        = o_imem_addr;
      data_wait       = 1'b1;
      data_delay      = $random(seed) & 3;
    end else if (o_imem_valid && !i_imem_addr_ok) begin
      if (!addr_counting) begin
        addr_counting = 1'b1;
        addr_delay    = $random(seed) & 3;
      end
      if (addr_delay == 0) begin
        i_imem_addr_ok <= 1'b1;
        addr_counting = 1'b0;
      end else begin
        addr_delay--;
      end
    end
    if (data_wait) begin
      if (data_delay == 0) begin
        i_imem_data_ok <= 1'b1;
        i_imem_rdata   <= image_word(req_addr);
        data_wait = 1'b0;
      end else begin
        data_delay--;
      end
    end
  endtask

  task automatic take_slot(input string pc_name, input string instr_name,
                           input pc_t pc, input instr_t instr);
    assert (pc == exp_pc) else report_mismatch(pc_name, pc, exp_pc);
    assert (instr == image_word(pc)) else report_mismatch(instr_name, instr, image_word(pc));
    exp_pc = exp_pc + 32'd4;
    issued++;
  endtask

  task automatic follow_issue();
    if (hold_check) begin
      assert (o_issue0_valid == hold_v0)
        else report_mismatch("o_issue0_valid", o_issue0_valid, hold_v0);
      assert (o_issue1_valid == hold_v1)
        else report_mismatch("o_issue1_valid", o_issue1_valid, hold_v1);
      assert (o_issue0_pc == hold_pc0)
        else report_mismatch("o_issue0_pc", o_issue0_pc, hold_pc0);
      assert (o_issue1_pc == hold_pc1)
        else report_mismatch("o_issue1_pc", o_issue1_pc, hold_pc1);
      assert (o_issue0_instr == hold_in0)
        else report_mismatch("o_issue0_instr", o_issue0_instr, hold_in0);
      assert (o_issue1_instr == hold_in1)
        else report_mismatch("o_issue1_instr", o_issue1_instr, hold_in1);
    end
    if (i_redirect) begin
      // old stream ends on this edge
      exp_pc = i_redirect_pc;
      redir_idx++;
      redir_pending = 1'b0;
    end else if (i_issue_ready && o_issue0_valid) begin
      take_slot("o_issue0_pc", "o_issue0_instr", o_issue0_pc, o_issue0_instr);
      if (o_issue1_valid) begin
        both_seen++;
        take_slot("o_issue1_pc", "o_issue1_instr", o_issue1_pc, o_issue1_instr);
      end
    end
    hold_check = o_issue0_valid && !i_issue_ready && !i_redirect;
    hold_v0  = o_issue0_valid;
    hold_v1  = o_issue1_valid;
    hold_pc0 = o_issue0_pc;
    hold_pc1 = o_issue1_pc;
    hold_in0 = o_issue0_instr;
    hold_in1 = o_issue1_instr;
  endtask

  task automatic steer_inputs();
    if (!redir_pending && redir_idx < n_redirect &&
        issued >= tests_mem[redir_base + 2 * redir_idx]) begin
      i_redirect    <= 1'b1;
      i_redirect_pc <= tests_mem[redir_base + 2 * redir_idx + 1];
      i_issue_ready <= 1'b0;
      redir_pending = 1'b1;
    end else begin
      i_redirect <= 1'b0;
      if (stall_left > 0) begin
        i_issue_ready <= 1'b0;
        stall_left--;
      end else if (($random(seed) & 63) == 0) begin
        // long enough for the buffer to fill
        i_issue_ready <= 1'b0;
        stall_left = 48 + ($random(seed) & 31);
      end else begin
        i_issue_ready <= (($random(seed) & 3) != 0);
      end
    end
  endtask

  always @(posedge aclk) begin
    if (i_rst_n) begin
      active_cycles++;
      assert (dut.u_chk.fail_count == 0)
        else report_error("bound protocol assertion failed");
      memory_port_rules();
      respond_memory();
      follow_issue();
      steer_inputs();
    end
  end

  initial begin
    wait (loaded);
    repeat (RST_CYCLES + CYCLES_PER_INSTR * n_instr) @(posedge aclk);
    report_error($sformatf("timeout with %0d of %0d instructions issued", issued, n_instr));
  end

  initial begin
    seed           = 55711;
    i_rst_n        = 1'b0;
    i_redirect     = 1'b0;
    i_redirect_pc  = '0;
    i_imem_addr_ok = 1'b0;
    i_imem_data_ok = 1'b0;
    i_imem_rdata   = '0;
    i_issue_ready  = 1'b0;
    exp_pc         = `PC_RESET;
    $readmemh("verification/frontend_tests.txt", tests_mem);
    n_image    = tests_mem[0];
    n_redirect = tests_mem[1];
    n_instr    = tests_mem[2];
    redir_base = 3 + 2 * n_image;
    assert (n_instr > 0) else report_error("test file holds no instructions");
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge aclk);
    i_rst_n <= 1'b1;
    wait (issued >= n_instr && redir_idx >= n_redirect);
    @(negedge aclk);
    assert (dut.u_chk.fail_count == 0)
      else report_error("bound protocol assertion failed");
    assert (both_seen > 0) else report_error("both issue slots were never taken together");
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/frontend_pkg.sv
design/fetch_push_if.sv
design/ib_pop_if.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/issue_stage.sv
design/frontend_top.sv
verification/frontend_chk.sv
verification/frontend_tb.sv

//--- verification/frontend_tests.txt
// header: image entries, redirect count, instructions to issue
// image lines: address word; redirect lines: issued count, target pc
00000018 00000003 00000040
1c000000 02bffc63
1c000004 0015000d
1c000008 02803c0c
1c00000c 0010b18d
1c000010 28c0018e
1c000014 29c0018f
1c000018 0040a1ad
1c00001c 5c0010a4
1c000020 02c00421
1c000024 03400000
1c000028 1400000c
1c00002c 4c000020
1c000100 02ffc063
1c000104 29c06061
1c000108 15ffffe4
1c00010c 0380f084
1c000110 00150085
1c000114 50001800
1c000118 28c06061
1c00011c 4c000020
1c000200 001500a6
1c000204 0010c4c6
1c000208 58000cc5
1c00020c 53fff3ff
0000000a 1c000100
00000016 1c000200
00000026 1c000040
